// ==== armCore.sv ====
// ###################
// Five-stage ARM subset core: DP, LDR, STR, conditional execution
// Instruction and data memories are external and answer combinationally
// Data memory writes on the rising edge while memWriteM is high
// ###################
`timescale 1ns/1ps

module armCore import armPkg::*;
#(
   parameter logic [DataWidth-1:0] ResetPc = '0
)
(
   input  logic                 clk,
   input  logic                 reset,
   output logic [DataWidth-1:0] pcF,
   input  logic [DataWidth-1:0] instrF,
   output logic                 memWriteM,
   output logic [DataWidth-1:0] aluOutM,
   output logic [DataWidth-1:0] writeDataM,
   input  logic [DataWidth-1:0] readDataM
);

   logic [DataWidth-1:0]    rd1D, rd2D, resultW;
   logic [RegAddrWidth-1:0] ra1D, ra2D, wa3W;
   logic                    regWriteW;
   logic [1:0]              forwardA, forwardB;
   logic                    stall, flushE;

   execIf exBus ();
   memIf  memBus ();

   armFetchDecode #(.ResetPc(ResetPc)) fetchDecode (
      .clk(clk), .reset(reset), .instrF(instrF), .stall(stall), .flushE(flushE),
      .rd1D(rd1D), .rd2D(rd2D), .pcF(pcF), .ra1D(ra1D), .ra2D(ra2D), .ex(exBus.decode));

   regFile regs (
      .clk(clk), .regWriteW(regWriteW), .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
      .resultW(resultW), .rd1D(rd1D), .rd2D(rd2D));

   armExecute execute (
      .clk(clk), .reset(reset), .forwardA(forwardA), .forwardB(forwardB),
      .resultW(resultW), .ex(exBus.execute), .mem(memBus.execute));

   armMemWb memWb (
      .clk(clk), .reset(reset), .readDataM(readDataM), .mem(memBus.memWb),
      .resultW(resultW), .wa3W(wa3W), .regWriteW(regWriteW));

   armHazard hazard (
      .ex(exBus.hazard), .mem(memBus.hazard), .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
      .regWriteW(regWriteW), .forwardA(forwardA), .forwardB(forwardB),
      .stall(stall), .flushE(flushE));

   // Memory stage to the data memory
   assign memWriteM  = memBus.memWrite;
   assign aluOutM    = memBus.aluOut;
   assign writeDataM = memBus.writeData;

endmodule

// ==== armExecute.sv ====
// ###################
// Execute stage with operand forwarding, ALU and NZCV register
// Condition 1111 never executes
// ###################
`timescale 1ns/1ps

module armExecute import armPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic [1:0]           forwardA,
   input  logic [1:0]           forwardB,
   input  logic [DataWidth-1:0] resultW,
   execIf.execute               ex,
   memIf.execute                mem
);

   logic [DataWidth-1:0] srcA, srcB, writeDataE, aluResult;
   logic [DataWidth:0]   sum;
   logic [3:0]           aluFlags, flags;
   logic                 isSub, addSub, condEx, ge;

   function automatic logic [DataWidth-1:0] pickOperand(input logic [1:0]           sel,
                                                        input logic [DataWidth-1:0] regVal,
                                                        input logic [DataWidth-1:0] memVal,
                                                        input logic [DataWidth-1:0] wbVal);
      case (sel)
         FwdMem:  return memVal;
         FwdWb:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   assign srcA       = pickOperand(forwardA, ex.rd1, mem.aluOut, resultW);
   assign writeDataE = pickOperand(forwardB, ex.rd2, mem.aluOut, resultW);
   assign srcB       = ex.aluSrc ? ex.extImm : writeDataE;

   assign isSub  = (ex.aluControl == AluSub);
   assign addSub = (ex.aluControl == AluAdd) || isSub;
   assign sum    = {1'b0, srcA} + {1'b0, isSub ? ~srcB : srcB} + (DataWidth+1)'(isSub);

   always_comb
   begin
      case (ex.aluControl)
         AluAnd:  aluResult = srcA & srcB;
         AluOrr:  aluResult = srcA | srcB;
         default: aluResult = sum[DataWidth-1:0];
      endcase
   end

   assign aluFlags[FlagN] = aluResult[DataWidth-1];
   assign aluFlags[FlagZ] = (aluResult == '0);
   assign aluFlags[FlagC] = addSub && sum[DataWidth];
   // Operands of equal sign giving a result of the other sign
   assign aluFlags[FlagV] = addSub && !(srcA[DataWidth-1] ^ srcB[DataWidth-1] ^ isSub)
                            && (srcA[DataWidth-1] ^ sum[DataWidth-1]);

   assign ge = (flags[FlagN] == flags[FlagV]);

   always_comb
   begin
      case (ex.cond)
         4'b0000: condEx = flags[FlagZ];                      // EQ
         4'b0001: condEx = !flags[FlagZ];
         4'b0010: condEx = flags[FlagC];                      // CS
         4'b0011: condEx = !flags[FlagC];
         4'b0100: condEx = flags[FlagN];
         4'b0101: condEx = !flags[FlagN];
         4'b0110: condEx = flags[FlagV];
         4'b0111: condEx = !flags[FlagV];
         4'b1000: condEx = flags[FlagC] && !flags[FlagZ];     // HI
         4'b1001: condEx = !(flags[FlagC] && !flags[FlagZ]);  // LS
         4'b1010: condEx = ge;
         4'b1011: condEx = !ge;
         4'b1100: condEx = !flags[FlagZ] && ge;               // GT
         4'b1101: condEx = !(!flags[FlagZ] && ge);
         CondAl:  condEx = 1'b1;
         default: condEx = 1'b0;
      endcase
   end

   // NZ and CV pairs update separately
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (ex.flagWrite[1] && condEx)
         begin
            flags[FlagN] <= aluFlags[FlagN];
            flags[FlagZ] <= aluFlags[FlagZ];
         end
         if (ex.flagWrite[0] && condEx)
         begin
            flags[FlagC] <= aluFlags[FlagC];
            flags[FlagV] <= aluFlags[FlagV];
         end
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         mem.regWrite <= 1'b0;
         mem.memWrite <= 1'b0;
         mem.memToReg <= 1'b0;
      end
      else
      begin
         mem.regWrite <= ex.regWrite && condEx;
         mem.memWrite <= ex.memWrite && condEx;
         mem.memToReg <= ex.memToReg;
      end
   end

   always_ff @(posedge clk)
   begin
      mem.aluOut    <= aluResult;
      mem.writeData <= writeDataE;
      mem.wa3       <= ex.wa3;
   end

endmodule

// ==== armFetchDecode.sv ====
// ###################
// Fetch and decode stages
// PC steps by 4 only, no branches and no R15 access
// Stall holds PC and instruction register; flushE inserts a bubble
// ###################
`timescale 1ns/1ps

module armFetchDecode import armPkg::*;
#(
   parameter logic [DataWidth-1:0] ResetPc = '0
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [DataWidth-1:0]    instrF,
   input  logic                    stall,
   input  logic                    flushE,
   input  logic [DataWidth-1:0]    rd1D,
   input  logic [DataWidth-1:0]    rd2D,
   output logic [DataWidth-1:0]    pcF,
   output logic [RegAddrWidth-1:0] ra1D,
   output logic [RegAddrWidth-1:0] ra2D,
   execIf.decode                   ex
);

   instrU                instrD;
   logic                 isDp, isMem, isStore;
   logic [DataWidth-1:0] extImmD;
   logic [1:0]           aluControlD;
   logic                 addSubD;
   logic [1:0]           flagWriteD;
   logic                 regWriteD, memWriteD, memToRegD;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pcF    <= ResetPc;
         instrD <= '0;   // Decodes as ANDEQ without S
      end
      else if (!stall)
      begin
         pcF    <= pcF + DataWidth'(4);
         instrD <= instrF;
      end
   end

   assign isDp    = (instrD.dp.op == OpDp);
   assign isMem   = (instrD.mem.op == OpMem);
   assign isStore = isMem && !instrD.mem.lBit;

   // Store data comes from rd, everything else reads rm
   assign ra1D = instrD.dp.rn;
   assign ra2D = isStore ? instrD.mem.rd : instrD.dp.imm8[RegAddrWidth-1:0];

   assign extImmD = isMem ? DataWidth'(instrD.mem.imm12) : DataWidth'(instrD.dp.imm8);

   always_comb
   begin
      aluControlD = AluAdd;   // LDR/STR address
      if (isDp)
      begin
         case (instrD.dp.cmd)
            CmdAdd:  aluControlD = AluAdd;
            CmdSub:  aluControlD = AluSub;
            CmdAnd:  aluControlD = AluAnd;
            CmdOrr:  aluControlD = AluOrr;
            default: aluControlD = AluAdd;
         endcase
      end
   end

   // C and V only make sense for the adder
   assign addSubD       = (aluControlD == AluAdd) || (aluControlD == AluSub);
   assign flagWriteD[1] = isDp && instrD.dp.sBit;
   assign flagWriteD[0] = isDp && instrD.dp.sBit && addSubD;

   assign regWriteD = isDp || (isMem && instrD.mem.lBit);
   assign memWriteD = isStore;
   assign memToRegD = isMem && instrD.mem.lBit;

   // Execute register, controls
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset || flushE)
      begin
         ex.aluControl <= '0;
         ex.aluSrc     <= 1'b0;
         ex.flagWrite  <= '0;
         ex.regWrite   <= 1'b0;
         ex.memWrite   <= 1'b0;
         ex.memToReg   <= 1'b0;
      end
      else
      begin
         ex.aluControl <= aluControlD;
         ex.aluSrc     <= isMem || instrD.dp.immBit;
         ex.flagWrite  <= flagWriteD;
         ex.regWrite   <= regWriteD;
         ex.memWrite   <= memWriteD;
         ex.memToReg   <= memToRegD;
      end
   end

   // Execute register, operands and indices
   always_ff @(posedge clk)
   begin
      ex.rd1    <= rd1D;
      ex.rd2    <= rd2D;
      ex.extImm <= extImmD;
      ex.ra1    <= ra1D;
      ex.ra2    <= ra2D;
      ex.wa3    <= instrD.dp.rd;
      ex.cond   <= instrD.dp.cond;
   end

endmodule

// ==== armHazard.sv ====
// ###################
// Forwarding selects and load-use stall, purely combinational
// ###################
`timescale 1ns/1ps

module armHazard import armPkg::*;
(
   execIf.hazard                   ex,
   memIf.hazard                    mem,
   input  logic [RegAddrWidth-1:0] ra1D,
   input  logic [RegAddrWidth-1:0] ra2D,
   input  logic [RegAddrWidth-1:0] wa3W,
   input  logic                    regWriteW,
   output logic [1:0]              forwardA,
   output logic [1:0]              forwardB,
   output logic                    stall,
   output logic                    flushE
);

   logic loadUse;

   // Memory stage wins, it holds the younger result
   function automatic logic [1:0] fwdFor(input logic [RegAddrWidth-1:0] ra,
                                         input logic [RegAddrWidth-1:0] wa3M,
                                         input logic                    regWriteM,
                                         input logic [RegAddrWidth-1:0] wa3Wb,
                                         input logic                    regWriteWb);
      if (regWriteM && (wa3M == ra))
         return FwdMem;
      else if (regWriteWb && (wa3Wb == ra))
         return FwdWb;
      return FwdNone;
   endfunction

   assign forwardA = fwdFor(ex.ra1, mem.wa3, mem.regWrite, wa3W, regWriteW);
   assign forwardB = fwdFor(ex.ra2, mem.wa3, mem.regWrite, wa3W, regWriteW);

   assign loadUse = ex.memToReg && ((ex.wa3 == ra1D) || (ex.wa3 == ra2D));

   // One bubble behind a load
   assign stall  = loadUse;
   assign flushE = loadUse;

endmodule

// ==== armIf.sv ====
// ###################
// Stage bundles between the pipeline blocks
// All signals are registered by the driving stage
// ###################
`timescale 1ns/1ps

// Execute-stage register contents
interface execIf import armPkg::*; ();
   logic [DataWidth-1:0]    rd1, rd2, extImm;
   logic [RegAddrWidth-1:0] ra1, ra2, wa3;
   logic [3:0]              cond;
   logic [1:0]              aluControl;
   logic                    aluSrc;
   logic [1:0]              flagWrite;   // [1] NZ, [0] CV
   logic                    regWrite, memWrite, memToReg;

   modport decode (output rd1, rd2, extImm, ra1, ra2, wa3, cond,
                   output aluControl, aluSrc, flagWrite, regWrite, memWrite, memToReg);
   modport execute (input rd1, rd2, extImm, ra1, ra2, wa3, cond,
                    input aluControl, aluSrc, flagWrite, regWrite, memWrite, memToReg);
   modport hazard (input ra1, ra2, wa3, memToReg);
endinterface

// Memory-stage register contents, write enables already condition gated
interface memIf import armPkg::*; ();
   logic [DataWidth-1:0]    aluOut, writeData;
   logic [RegAddrWidth-1:0] wa3;
   logic                    regWrite, memWrite, memToReg;

   modport execute (output aluOut, writeData, wa3, regWrite, memWrite, memToReg);
   modport memWb (input aluOut, wa3, regWrite, memToReg);
   modport hazard (input wa3, regWrite);
endinterface

// ==== armMemWb.sv ====
// ###################
// Memory to writeback register and result select
// Load data must be valid in the same cycle as the address
// ###################
`timescale 1ns/1ps

module armMemWb import armPkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [DataWidth-1:0]    readDataM,
   memIf.memWb                     mem,
   output logic [DataWidth-1:0]    resultW,
   output logic [RegAddrWidth-1:0] wa3W,
   output logic                    regWriteW
);

   logic [DataWidth-1:0] aluOutW, readDataW;
   logic                 memToRegW;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         regWriteW <= 1'b0;
         memToRegW <= 1'b0;
      end
      else
      begin
         regWriteW <= mem.regWrite;
         memToRegW <= mem.memToReg;
      end
   end

   always_ff @(posedge clk)
   begin
      aluOutW   <= mem.aluOut;
      readDataW <= readDataM;
      wa3W      <= mem.wa3;
   end

   assign resultW = memToRegW ? readDataW : aluOutW;   // LDR takes memory data

endmodule

// ==== armPkg.sv ====
// ###################
// Constants and instruction views shared by the ARM subset core
// Only DP (op 00) and LDR/STR (op 01) are decoded; other op values act as no-ops
// Flag word is {N, Z, C, V}, N in the top bit
// ###################
package armPkg;

   localparam int DataWidth    = 32;
   localparam int RegAddrWidth = 4;

   // Op field
   localparam logic [1:0] OpDp  = 2'b00;
   localparam logic [1:0] OpMem = 2'b01;

   // Data-processing cmd field
   localparam logic [3:0] CmdAnd = 4'b0000;
   localparam logic [3:0] CmdSub = 4'b0010;
   localparam logic [3:0] CmdAdd = 4'b0100;
   localparam logic [3:0] CmdOrr = 4'b1100;

   localparam logic [1:0] AluAdd = 2'b00;
   localparam logic [1:0] AluSub = 2'b01;
   localparam logic [1:0] AluAnd = 2'b10;
   localparam logic [1:0] AluOrr = 2'b11;

   // Operand source in execute
   localparam logic [1:0] FwdNone = 2'b00;
   localparam logic [1:0] FwdWb   = 2'b01;
   localparam logic [1:0] FwdMem  = 2'b10;

   localparam logic [3:0] CondAl = 4'b1110;

   localparam int FlagN = 3;
   localparam int FlagZ = 2;
   localparam int FlagC = 1;
   localparam int FlagV = 0;

   typedef struct packed {
      logic [3:0]              cond;
      logic [1:0]              op;
      logic                    immBit;
      logic [3:0]              cmd;
      logic                    sBit;
      logic [RegAddrWidth-1:0] rn;
      logic [RegAddrWidth-1:0] rd;
      logic [3:0]              rotate;   // Ignored, no rotated immediates
      logic [7:0]              imm8;     // Low nibble is rm in register form
   } dpFields;

   typedef struct packed {
      logic [3:0]              cond;
      logic [1:0]              op;
      logic [4:0]              funct;
      logic                    lBit;     // 1 for LDR
      logic [RegAddrWidth-1:0] rn;
      logic [RegAddrWidth-1:0] rd;
      logic [11:0]             imm12;
   } memFields;

   typedef union packed {
      dpFields  dp;
      memFields mem;
   } instrU;

endpackage

// ==== armTb.sv ====
// ###################
// Directed and random tests for the ARM subset core
// Memories are 256 words indexed by address bits 9:2
// Programs stay below 240 words so the PC never wraps
// ###################
`timescale 1ns/1ps

module armTb import armPkg::*; ();

   localparam logic [DataWidth-1:0] ResetPc = 32'h0;
   localparam logic [31:0] Seed = 32'h63906890;
   localparam int ImemDepth   = 256;
   localparam int DmemDepth   = 256;
   localparam int ResetCycles = 10;
   localparam int DrainCycles = 10;
   localparam int RunCount    = 6;   // Reset, DP, load-use, cond, two random runs
   localparam int WatchdogCycles = RunCount * (2 * ResetCycles + ImemDepth + DrainCycles) + 100;

   logic                 clk, porReset, testReset, reset;
   logic [DataWidth-1:0] pcF, instrF, aluOutM, writeDataM, readDataM;
   logic                 memWriteM;

   logic [DataWidth-1:0] imem [0:ImemDepth-1];
   logic [DataWidth-1:0] dmem [0:DmemDepth-1];
   logic [DataWidth-1:0] refMem [0:DmemDepth-1];
   logic [DataWidth-1:0] refRegs [0:14];
   logic [3:0]           refFlags;   // {N, Z, C, V}
   logic [DataWidth-1:0] expAddr [$];
   logic [DataWidth-1:0] expData [$];
   int                   progLen, storeOff;

   tbClock #(.Period(20), .ResetCycles(ResetCycles)) clockGen (.clk(clk), .reset(porReset));

   assign reset = porReset | testReset;

   armCore #(.ResetPc(ResetPc)) armCore_inst (
      .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF), .memWriteM(memWriteM),
      .aluOutM(aluOutM), .writeDataM(writeDataM), .readDataM(readDataM));

   // Combinational memories
   assign instrF    = imem[pcF[9:2]];
   assign readDataM = dmem[aluOutM[9:2]];

   always @(posedge clk)
   begin
      if (memWriteM)
         dmem[aluOutM[9:2]] = writeDataM;
   end

   task automatic stopOnError(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
      if (got !== exp)
         stopOnError($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stopOnError($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   function automatic logic [31:0] encDp(input logic [3:0] cond, input logic [3:0] cmd,
                                         input logic immForm, input logic s,
                                         input logic [3:0] rn, input logic [3:0] rd,
                                         input logic [7:0] op2);
      return {cond, OpDp, immForm, cmd, s, rn, rd, 4'h0, op2};   // op2 low nibble is rm
   endfunction

   function automatic logic [31:0] encMem(input logic [3:0] cond, input logic load,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [11:0] imm12);
      return {cond, OpMem, 5'b01100, load, rn, rd, imm12};
   endfunction

   function automatic logic [31:0] fillWord(input int idx);
      return 32'hC3000000 ^ (idx * 32'h00010307);
   endfunction

   function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
      logic n, z, c, v;
      n = f[3];
      z = f[2];
      c = f[1];
      v = f[0];
      case (cond)
         4'd0:    return z;
         4'd1:    return !z;
         4'd2:    return c;
         4'd3:    return !c;
         4'd4:    return n;
         4'd5:    return !n;
         4'd6:    return v;
         4'd7:    return !v;
         4'd8:    return c && !z;
         4'd9:    return !c || z;
         4'd10:   return n == v;
         4'd11:   return n != v;
         4'd12:   return !z && (n == v);
         4'd13:   return z || (n != v);
         4'd14:   return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[progLen] = word;
      progLen++;
   endtask

   task automatic storeReg(input logic [3:0] rd);
      emit(encMem(CondAl, 1'b0, 4'd14, rd, storeOff[11:0]));
      storeOff += 4;
   endtask

   task automatic fillMemories();
      for (int i = 0; i < ImemDepth; i++)
         imem[i] = 32'hF0000000 | i;   // Never-executed filler
      for (int i = 0; i < DmemDepth; i++)
      begin
         dmem[i]   = fillWord(i);
         refMem[i] = fillWord(i);
      end
   endtask

   // Holds reset, clears memories and zeroes R0 to R14 (R14 is the store base)
   task automatic newProgram();
      @(posedge clk);
      #2 testReset = 1'b1;
      progLen  = 0;
      storeOff = 0;
      expAddr.delete();
      expData.delete();
      fillMemories();
      for (int r = 0; r < 15; r++)
         emit(encDp(CondAl, CmdAnd, 1'b1, 1'b0, r[3:0], r[3:0], 8'h00));
   endtask

   // Sequential model that fills the expected store queues
   task automatic modelProgram();
      logic [31:0] w, a, b, r, addr;
      logic [32:0] wide;
      logic        c, v, isArith;
      for (int i = 0; i < 15; i++)
         refRegs[i] = '0;
      refFlags = '0;
      for (int pc = 0; pc < progLen; pc++)
      begin
         w = imem[pc];
         if (!condHolds(w[31:28], refFlags))
            continue;
         if (w[27:26] == OpDp)
         begin
            a = refRegs[w[19:16]];
            b = w[25] ? {24'h0, w[7:0]} : refRegs[w[3:0]];
            isArith = 1'b1;
            c = 1'b0;
            v = 1'b0;
            case (w[24:21])
               CmdAdd:
               begin
                  wide = {1'b0, a} + {1'b0, b};
                  r = wide[31:0];
                  c = wide[32];
                  v = (a[31] == b[31]) && (r[31] != a[31]);
               end
               CmdSub:
               begin
                  r = a - b;
                  c = (a >= b);   // No borrow
                  v = (a[31] != b[31]) && (r[31] != a[31]);
               end
               CmdAnd:
               begin
                  r = a & b;
                  isArith = 1'b0;
               end
               default:
               begin
                  r = a | b;
                  isArith = 1'b0;
               end
            endcase
            refRegs[w[15:12]] = r;
            if (w[20])
            begin
               refFlags[3:2] = {r[31], r == 32'h0};
               if (isArith)
                  refFlags[1:0] = {c, v};
            end
         end
         else
         begin
            addr = refRegs[w[19:16]] + {20'h0, w[11:0]};
            if (w[20])
               refRegs[w[15:12]] = refMem[addr[9:2]];
            else
            begin
               refMem[addr[9:2]] = refRegs[w[15:12]];
               expAddr.push_back(addr);
               expData.push_back(refRegs[w[15:12]]);
            end
         end
      end
   endtask

   task automatic runProgram(input int expRepeats);
      logic [DataWidth-1:0] lastPc;
      int                   repeats;
      modelProgram();
      repeat (ResetCycles)
      begin
         @(negedge clk);
         checkBit("memWriteM", memWriteM, 1'b0);
         checkWord("pcF", pcF, ResetPc);
      end
      @(posedge clk);
      #2 testReset = 1'b0;
      lastPc  = ResetPc - 32'd4;
      repeats = 0;
      for (int cyc = 0; cyc < progLen + DrainCycles + expRepeats; cyc++)
      begin
         @(negedge clk);
         if (pcF === lastPc)
            repeats++;
         else
            checkWord("pcF", pcF, lastPc + 32'd4);
         lastPc = pcF;
         if (memWriteM === 1'b1)
         begin
            if (expAddr.size() == 0)
               stopOnError($sformatf("Unexpected store to %h at %0t", aluOutM, $time));
            checkWord("aluOutM", aluOutM, expAddr.pop_front());
            checkWord("writeDataM", writeDataM, expData.pop_front());
         end
      end
      if (expAddr.size() != 0)
         stopOnError($sformatf("%0d expected stores never happened", expAddr.size()));
      checkWord("pcF repeat count", repeats, expRepeats);
   endtask

   task automatic resetTest();
      newProgram();
      storeReg(4'd0);
      runProgram(0);
   endtask

   task automatic forwardingTest();
      newProgram();
      emit(encDp(CondAl, CmdOrr, 1'b1, 1'b0, 4'd1, 4'd1, 8'h35));
      emit(encDp(CondAl, CmdAdd, 1'b1, 1'b0, 4'd1, 4'd2, 8'h10));
      storeReg(4'd2);
      emit(encDp(CondAl, CmdSub, 1'b0, 1'b0, 4'd2, 4'd3, 8'd1));
      emit(encDp(CondAl, CmdAnd, 1'b0, 1'b0, 4'd3, 4'd4, 8'd2));
      emit(encDp(CondAl, CmdOrr, 1'b0, 1'b0, 4'd4, 4'd5, 8'd1));
      emit(encDp(CondAl, CmdAdd, 1'b0, 1'b0, 4'd5, 4'd6, 8'd3));
      storeReg(4'd6);
      emit(encDp(CondAl, CmdSub, 1'b1, 1'b0, 4'd1, 4'd7, 8'h40));
      storeReg(4'd7);
      emit(encDp(CondAl, CmdAdd, 1'b0, 1'b0, 4'd7, 4'd8, 8'd7));
      storeReg(4'd8);
      storeReg(4'd3);
      storeReg(4'd4);
      storeReg(4'd5);
      runProgram(0);
   endtask

   task automatic loadUseTest();
      newProgram();
      emit(encDp(CondAl, CmdOrr, 1'b1, 1'b0, 4'd1, 4'd1, 8'h5C));
      storeReg(4'd1);
      emit(encMem(CondAl, 1'b1, 4'd14, 4'd2, 12'h000));
      emit(encDp(CondAl, CmdAdd, 1'b1, 1'b0, 4'd2, 4'd3, 8'h05));
      storeReg(4'd3);
      emit(encMem(CondAl, 1'b1, 4'd14, 4'd4, 12'h200));   // Untouched fill word
      emit(encDp(CondAl, CmdAdd, 1'b0, 1'b0, 4'd3, 4'd5, 8'd4));
      storeReg(4'd5);
      runProgram(2);
   endtask

   task automatic condSweep();
      for (int cc = 0; cc < 15; cc++)
      begin
         emit(encDp(cc[3:0], CmdAdd, 1'b1, 1'b0, 4'd1, 4'd1, 8'(cc + 1)));
         storeReg(4'd1);
      end
   endtask

   task automatic conditionTest();
      newProgram();
      emit(encDp(CondAl, CmdOrr, 1'b1, 1'b0, 4'd9, 4'd9, 8'h01));
      repeat (31)
         emit(encDp(CondAl, CmdAdd, 1'b0, 1'b0, 4'd9, 4'd9, 8'd9));   // R9 = 0x80000000
      emit(encDp(CondAl, CmdSub, 1'b1, 1'b1, 4'd0, 4'd0, 8'h01));     // N set, C clear
      condSweep();
      emit(encDp(CondAl, CmdAdd, 1'b1, 1'b1, 4'd0, 4'd11, 8'h01));    // Z and C set
      condSweep();
      emit(encMem(4'b0001, 1'b0, 4'd14, 4'd1, 12'h3F0));             // STRNE must not fire
      emit(encDp(CondAl, CmdSub, 1'b1, 1'b1, 4'd9, 4'd10, 8'h01));    // C and V set
      condSweep();
      emit(encDp(CondAl, CmdAdd, 1'b1, 1'b1, 4'd11, 4'd12, 8'h01));   // All flags clear
      condSweep();
      runProgram(0);
   endtask

   task automatic randomTest();
      logic [3:0] cmds [0:3];
      logic [3:0] rd;
      logic       immForm;
      cmds = '{CmdAdd, CmdSub, CmdAnd, CmdOrr};
      for (int run = 0; run < 2; run++)
      begin
         newProgram();
         for (int k = 0; k < 100; k++)
         begin
            rd      = 4'($urandom % 13);
            immForm = 1'($urandom % 2);
            emit(encDp(4'($urandom % 16), cmds[$urandom % 4], immForm, 1'($urandom % 2),
                       4'($urandom % 13), rd, immForm ? 8'($urandom % 256) : 8'($urandom % 13)));
            storeReg(rd);
         end
         runProgram(0);
      end
   endtask

   initial
   begin
      repeat (WatchdogCycles) @(posedge clk);
      $display("Simulation timed out after %0d cycles", WatchdogCycles);
      $display("ERRORS FOUND");
      $fatal(1);
   end

   initial
   begin
      void'($urandom(Seed));
      testReset = 1'b1;
      fillMemories();
      @(negedge porReset);
      resetTest();
      forwardingTest();
      loadUseTest();
      conditionTest();
      randomTest();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== flist.f ====
armPkg.sv
armIf.sv
armFetchDecode.sv
regFile.sv
armExecute.sv
armMemWb.sv
armHazard.sv
armCore.sv
tbClock.sv
armTb.sv

// ==== regFile.sv ====
// ###################
// R0 to R14 only, R15 is not implemented
// Written on the falling edge so decode sees writeback data in the same cycle
// ###################
`timescale 1ns/1ps

module regFile import armPkg::*;
(
   input  logic                    clk,
   input  logic                    regWriteW,
   input  logic [RegAddrWidth-1:0] ra1D,
   input  logic [RegAddrWidth-1:0] ra2D,
   input  logic [RegAddrWidth-1:0] wa3W,
   input  logic [DataWidth-1:0]    resultW,
   output logic [DataWidth-1:0]    rd1D,
   output logic [DataWidth-1:0]    rd2D
);

   logic [DataWidth-1:0] regs [0:14];

   always_ff @(negedge clk)
   begin
      if (regWriteW)
         regs[wa3W] <= resultW;
   end

   // Two async read ports
   assign rd1D = regs[ra1D];
   assign rd2D = regs[ra2D];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module armTb -f flist.f -o armSim

# The testbench stops with a nonzero status on failure, so the log decides
./obj_dir/armSim 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// ==== tbClock.sv ====
// ###################
// Testbench clock and power-on reset
// Reset is released 2 ns after the last held rising edge
// ###################
`timescale 1ns/1ps

module tbClock
#(
   parameter int Period      = 20,
   parameter int ResetCycles = 10
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(Period / 2) clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (ResetCycles) @(posedge clk);
      #2 reset = 1'b0;
   end

endmodule
